/* bench/board_input.txt */
# all fields hex: W addr data | R addr data | S status | C board_cmd | N cycles | A amp_dis cycles
# I neg pos home fault mv_faultn mv_good v_fault relay board_id temp safety
# reset values
A F 1
C 0
R 0004 514C4131
R 000F 00002000
I 0 0 0 0 1 0 0 1 5 0000 0
S 45000000
# amp enable ignored while power is off, then power, amps, relay, mode
W 0000 00000F0F
S 45000000
W 0000 000C0000
S 45040000
W 0000 00C30F0F
S 4545000F
R 0000 4545000F
C E
A F 1
# reboot pulse
W 0000 00300000
C F
N 1
C E
# motor voltage settle
I 0 0 0 0 1 1 0 1 5 0000 0
S 454D000F
N 14
A F 1
A 0 C8
I 0 0 0 0 1 0 0 1 5 0000 0
A F 2
I 0 0 0 0 1 1 0 1 5 0000 0
A 0 C8
# watchdog, period of 4 ticks
W 0003 00000004
R 0003 00000004
N 64
S 45CD0000
A F 1
W 0003 00000000
W 0000 000C0000
S 454D0000
W 0000 00000F0F
S 454D000F
A 0 2
# safety disable on axis 2
I 0 0 0 0 1 1 0 1 5 0000 2
S 454D002D
A 2 2
I 0 0 0 0 1 1 0 1 5 0000 0
S 454D000D
W 0000 00000202
S 454D000F
A 0 2
# read-only and data registers
I 1 2 4 3 1 1 1 1 5 1234 0
S 454D030F
R 0005 00001234
R 000A 80000124
W 000F DEADBEEF
R 000F DEADBEEF
W 001F 12345678
R 000F DEADBEEF
R 0007 00000000
R 1004 00000000

/* bench/tb_board_ctrl.sv */
/*
 * Testbench for the board control block: replays the command file
 * on the host bus and board inputs and checks the DUT responses.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_board_ctrl;

    import board_pkg::*;

    localparam string CMD_FILE = "bench/board_input.txt";

    // DUT signals
    logic       sysclk;
    logic       rst_n;
    reg_addr_t  reg_raddr;
    reg_addr_t  reg_waddr;
    reg_data_t  reg_wdata;
    logic       reg_wen;
    reg_data_t  reg_rdata;
    board_io_t  board_io;
    axis_mask_t safety_amp_disable;
    board_cmd_t board_cmd;
    axis_mask_t amp_disable;
    reg_data_t  reg_status;
    logic       pwr_enable_cmd;
    axis_mask_t amp_enable_cmd;

    // command file parsing
    integer             fd;
    integer             code;
    integer             err_cnt;
    integer             cmd_cnt;        // commands run, comments excluded
    logic               done;
    logic [7:0]         cmd;            // command letter
    logic [31:0]        a;
    logic [31:0]        d;
    logic [8*256-1:0]   comment_line;

    board_ctrl_top i_dut (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .reg_rdata          (reg_rdata),
        .board_io           (board_io),
        .safety_amp_disable (safety_amp_disable),
        .board_cmd          (board_cmd),
        .amp_disable        (amp_disable),
        .reg_status         (reg_status),
        .pwr_enable_cmd     (pwr_enable_cmd),
        .amp_enable_cmd     (amp_enable_cmd)
    );

    always #5 sysclk = ~sysclk;     // 10 ns period

    // ----------------------------------------------------------
    // failure reporting and checks
    // ----------------------------------------------------------
    task automatic abort_run;
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            err_cnt++;
            $display("error at %0t: %s got %h expected %h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic expect_fields(input integer got, input integer want);
        if (got != want)
            report_failure($sformatf("malformed %c command after %0d commands", cmd, cmd_cnt));
    endtask

    // ----------------------------------------------------------
    // bus and board drivers
    // ----------------------------------------------------------
    task automatic next_cycle;
        @(posedge sysclk);
        #1;                         // drive just after the edge
    endtask

    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        logic       to_status;      // main block, status offset
        logic       pwr_exp;
        axis_mask_t amp_exp;
        integer     n;
        to_status = (addr[15:12] == ADDR_MAIN) && (addr[7:4] == 4'd0) &&
                    (addr[3:0] == REG_STATUS);
        // a command fires when its mask and value bits are both set
        pwr_exp = to_status && data[19] && data[18];
        for (n = 0; n < NUM_AXES; n++)
            amp_exp[n] = to_status && data[8+n] && data[n];
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        #1;                         // decode of the write on the bus
        check_val("pwr_enable_cmd", {31'd0, pwr_enable_cmd}, {31'd0, pwr_exp});
        check_val("amp_enable_cmd", {28'd0, amp_enable_cmd}, {28'd0, amp_exp});
        next_cycle();
        reg_wen   = 1'b0;
    endtask

    task automatic bus_read_check(input reg_addr_t addr, input reg_data_t exp);
        reg_raddr = addr;
        reg_wen   = 1'b0;
        next_cycle();               // one cycle read latency
        check_val("reg_rdata", reg_rdata, exp);
    endtask

    task automatic load_board_inputs;
        logic [31:0] neg, pos, home, flt, mvf, mvg, vf, rly, id, temp, saf;
        integer      n;
        n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h",
                    neg, pos, home, flt, mvf, mvg, vf, rly, id, temp, saf);
        expect_fields(n, 11);
        board_io.neg_limit  = neg[3:0];
        board_io.pos_limit  = pos[3:0];
        board_io.home       = home[3:0];
        board_io.fault      = flt[3:0];
        board_io.mv_faultn  = mvf[0];
        board_io.mv_good    = mvg[0];
        board_io.v_fault    = vf[0];
        board_io.relay      = rly[0];   // feedback, active low
        board_io.board_id   = id[3:0];
        board_io.temp_sense = temp[15:0];
        safety_amp_disable  = saf[3:0];
        next_cycle();
    endtask

    task automatic wait_amp_disable(input axis_mask_t exp, input integer max_cycles);
        integer cnt;
        cnt = 0;
        while (amp_disable !== exp) begin
            if (cnt >= max_cycles) begin
                report_failure($sformatf(
                    "amp_disable did not reach %h within %0d cycles, still %h",
                    exp, max_cycles, amp_disable));
            end else begin
                next_cycle();
                cnt++;
            end
        end
    endtask

    task automatic idle_cycles(input integer n);
        reg_wen = 1'b0;
        repeat (n) next_cycle();
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        sysclk             = 1'b0;
        rst_n              = 1'b0;
        reg_raddr          = '0;
        reg_waddr          = '0;
        reg_wdata          = '0;
        reg_wen            = 1'b0;
        board_io           = '0;
        safety_amp_disable = '0;
        err_cnt            = 0;
        cmd_cnt            = 0;
        done               = 1'b0;

        fd = $fopen(CMD_FILE, "r");
        if (fd == 0)
            report_failure("could not open the command file bench/board_input.txt");

        repeat (2) @(posedge sysclk);
        #1 rst_n = 1'b1;

        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;                        // end of file
            end else if (cmd == "#") begin
                code = $fgets(comment_line, fd);
            end else begin
                cmd_cnt++;
                case (cmd)
                    "W": begin
                        code = $fscanf(fd, " %h %h", a, d);
                        expect_fields(code, 2);
                        bus_write(a[15:0], d);
                    end
                    "R": begin
                        code = $fscanf(fd, " %h %h", a, d);
                        expect_fields(code, 2);
                        bus_read_check(a[15:0], d);
                    end
                    "I": load_board_inputs();
                    "S": begin
                        code = $fscanf(fd, " %h", d);
                        expect_fields(code, 1);
                        check_val("reg_status", reg_status, d);
                    end
                    "C": begin
                        code = $fscanf(fd, " %h", d);
                        expect_fields(code, 1);
                        check_val("board_cmd", {28'd0, board_cmd}, d);
                    end
                    "A": begin
                        code = $fscanf(fd, " %h %h", d, a);
                        expect_fields(code, 2);
                        wait_amp_disable(d[3:0], a);
                    end
                    "N": begin
                        code = $fscanf(fd, " %h", a);
                        expect_fields(code, 1);
                        idle_cycles(a);
                    end
                    default: report_failure($sformatf("unknown command letter %c", cmd));
                endcase
            end
        end
        $fclose(fd);
        $display("%0d commands run", cmd_cnt);

        if (err_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* build.f */
verilog/board_pkg.sv
verilog/board_regs.sv
verilog/wdog_timer.sv
verilog/power_seq.sv
verilog/board_ctrl_top.sv
bench/tb_board_ctrl.sv

/* verilog/board_ctrl_top.sv */
/*
 * Board control top level: register block, host watchdog and motor
 * power sequencer of the four-axis amplifier board.
 */

`timescale 1ns/10ps
`default_nettype none

module board_ctrl_top (
    input  wire logic                  sysclk,
    input  wire logic                  rst_n,
    // host register bus
    input  wire board_pkg::reg_addr_t  reg_raddr,
    input  wire board_pkg::reg_addr_t  reg_waddr,
    input  wire board_pkg::reg_data_t  reg_wdata,
    input  wire logic                  reg_wen,
    output board_pkg::reg_data_t       reg_rdata,
    // board side
    input  wire board_pkg::board_io_t  board_io,
    input  wire board_pkg::axis_mask_t safety_amp_disable,
    output board_pkg::board_cmd_t      board_cmd,
    output board_pkg::axis_mask_t      amp_disable,
    output board_pkg::reg_data_t       reg_status,
    output logic                       pwr_enable_cmd,
    output board_pkg::axis_mask_t      amp_enable_cmd
);

    import board_pkg::*;

    // ----------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------
    axis_mask_t  amp_off;       // register block amp-off state
    wdog_count_t wdog_period;
    logic        host_write;
    logic        powerup_cmd;
    logic        wdog_timeout;
    logic        tick;          // shared timebase

    board_regs u_regs (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .reg_rdata          (reg_rdata),
        .board_io           (board_io),
        .safety_amp_disable (safety_amp_disable),
        .wdog_timeout       (wdog_timeout),
        .board_cmd          (board_cmd),
        .amp_off            (amp_off),
        .wdog_period        (wdog_period),
        .host_write         (host_write),
        .powerup_cmd        (powerup_cmd),
        .pwr_enable_cmd     (pwr_enable_cmd),
        .amp_enable_cmd     (amp_enable_cmd),
        .reg_status         (reg_status)
    );

    wdog_timer u_wdog (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .wdog_period  (wdog_period),
        .host_write   (host_write),
        .powerup_cmd  (powerup_cmd),
        .wdog_timeout (wdog_timeout),
        .tick         (tick)
    );

    power_seq u_pseq (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .tick        (tick),
        .mv_good     (board_io.mv_good),
        .amp_off     (amp_off),
        .amp_disable (amp_disable)
    );

endmodule

`default_nettype wire

/* verilog/board_pkg.sv */
/*
 * Board control package with the register map, bus and board types,
 * the sequencer states and the watchdog and settle timing constants.
 */

`default_nettype none

package board_pkg;

    // ----------------------------------------------------------
    // widths and vector types
    // ----------------------------------------------------------
    localparam int NUM_AXES = 4;            // amplifier channels on the board

    typedef logic [15:0]         reg_addr_t;    // host register address
    typedef logic [31:0]         reg_data_t;    // host register data word
    typedef logic [NUM_AXES-1:0] axis_mask_t;   // bit 0 is axis 1
    typedef logic [15:0]         wdog_count_t;  // watchdog period and counter

    // ----------------------------------------------------------
    // register map
    // ----------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN   = 4'd0;  // block number, addr[15:12]

    localparam logic [3:0] REG_STATUS  = 4'd0;  // rw, masked command bits
    localparam logic [3:0] REG_TIMEOUT = 4'd3;  // rw, watchdog period in ticks
    localparam logic [3:0] REG_VERSION = 4'd4;  // ro
    localparam logic [3:0] REG_TEMPSNS = 4'd5;  // ro, temperature sensor
    localparam logic [3:0] REG_DIGIN   = 4'd10; // ro, limits and home switches
    localparam logic [3:0] REG_DEBUG   = 4'd15; // rw scratch

    localparam reg_data_t BOARD_VERSION = 32'h514C_4131;   // "QLA1"
    localparam reg_data_t DEBUG_RESET   = 32'h0000_2000;

    // ----------------------------------------------------------
    // timing
    // ----------------------------------------------------------
    localparam int TICK_WIDTH      = 4;     // tick every 2**TICK_WIDTH sysclk
    localparam int MV_SETTLE_TICKS = 8;     // ticks of mv_good before amps may run
    localparam int SETTLE_CNT_W    = $clog2(MV_SETTLE_TICKS + 1);

    // ----------------------------------------------------------
    // grouped board signals
    // ----------------------------------------------------------
    typedef struct packed {
        axis_mask_t  neg_limit;     // negative limit switches
        axis_mask_t  pos_limit;     // positive limit switches
        axis_mask_t  home;          // home switches
        axis_mask_t  fault;         // amplifier fault, per axis
        logic        mv_faultn;     // motor supply fault, active low
        logic        mv_good;       // motor voltage good
        logic        v_fault;       // encoder supply fault
        logic        relay;         // relay feedback, active low
        logic [3:0]  board_id;      // rotary switch
        logic [15:0] temp_sense;    // raw temperature reading
    } board_io_t;

    typedef struct packed {
        logic pwr_enable;           // motor power enable
        logic relay_on;             // safety relay drive
        logic eth1394;              // 0 firewire, 1 ethernet bridge mode
        logic reboot;               // single-cycle reboot request
    } board_cmd_t;

    // power sequencer
    typedef enum logic [1:0] {
        PS_OFF,                     // no motor voltage, hold all axes off
        PS_SETTLE,                  // voltage up, waiting for it to settle
        PS_READY                    // amps follow the host command
    } pseq_state_t;

endpackage

`default_nettype wire

/* verilog/board_regs.sv */
/*
 * Board register block: decodes host writes into the masked command bits
 * and per-axis amp-off state, and serves status and read-only registers.
 */

`timescale 1ns/10ps
`default_nettype none

module board_regs (
    input  wire logic                 sysclk,
    input  wire logic                 rst_n,
    // host register bus
    input  wire board_pkg::reg_addr_t reg_raddr,
    input  wire board_pkg::reg_addr_t reg_waddr,
    input  wire board_pkg::reg_data_t reg_wdata,
    input  wire logic                 reg_wen,
    output board_pkg::reg_data_t      reg_rdata,     // one cycle after raddr
    // board sense inputs
    input  wire board_pkg::board_io_t  board_io,
    input  wire board_pkg::axis_mask_t safety_amp_disable,
    input  wire logic                  wdog_timeout,
    // commands and watchdog control
    output board_pkg::board_cmd_t     board_cmd,
    output board_pkg::axis_mask_t     amp_off,
    output board_pkg::wdog_count_t    wdog_period,
    output logic                      host_write,
    output logic                      powerup_cmd,
    output logic                      pwr_enable_cmd,
    output board_pkg::axis_mask_t     amp_enable_cmd,
    output board_pkg::reg_data_t      reg_status
);

    import board_pkg::*;

    logic       write_main;     // write hits the main block
    logic       write_status;   // write to the status/command register
    logic       read_main;      // read address in the main block
    axis_mask_t amp_mask;       // per-axis write masks, wdata[11:8]
    axis_mask_t amp_val;        // per-axis enable values, wdata[3:0]
    reg_data_t  reg_digin;      // packed switch inputs
    reg_data_t  reg_debug;      // scratch register

    // ----------------------------------------------------------
    // address decode
    // ----------------------------------------------------------
    assign write_main   = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) &&
                          (reg_waddr[7:4] == 4'd0);
    assign write_status = write_main && (reg_waddr[3:0] == REG_STATUS);
    assign read_main    = (reg_raddr[15:12] == ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    assign amp_mask = reg_wdata[8 +: NUM_AXES];
    assign amp_val  = reg_wdata[0 +: NUM_AXES];

    // host asking for power or amps, clears the watchdog
    assign pwr_enable_cmd = write_status & reg_wdata[19] & reg_wdata[18];
    assign amp_enable_cmd = write_status ? (amp_mask & amp_val) : '0;
    assign powerup_cmd    = pwr_enable_cmd | (|amp_enable_cmd);
    assign host_write     = reg_wen;        // any write restarts the watchdog

    // ----------------------------------------------------------
    // status and digital input packing
    // ----------------------------------------------------------
    assign reg_status = {
        4'(NUM_AXES), board_io.board_id,            // 31:24
        wdog_timeout, board_cmd.eth1394, 2'b00,     // 23:20
        board_io.mv_good, board_cmd.pwr_enable,     // 19:18
        ~board_io.relay, board_cmd.relay_on,        // 17:16, relay feedback is active low
        ~board_io.mv_faultn, 3'b000,                // 15:12
        board_io.fault,                             // 11:8
        safety_amp_disable,                         // 7:4
        ~amp_off                                    // 3:0, 1 means amp enabled
    };

    assign reg_digin = {board_io.v_fault, 19'd0, board_io.neg_limit,
                        board_io.pos_limit, board_io.home};

    // ----------------------------------------------------------
    // command bits, amp-off state and read data
    // ----------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            board_cmd   <= '0;
            amp_off     <= '1;              // all axes start disabled
            wdog_period <= '0;              // watchdog off
            reg_debug   <= DEBUG_RESET;
            reg_rdata   <= '0;
        end else begin
            // reboot only lives for the cycle after its write
            board_cmd.reboot <= write_status & reg_wdata[21] & reg_wdata[20];

            if (write_main) begin
                case (reg_waddr[3:0])
                    REG_STATUS: begin
                        // axis updates need power already on, else forced off
                        amp_off <= (amp_mask & ({NUM_AXES{~board_cmd.pwr_enable}} | ~amp_val)) |
                                   (~amp_mask & amp_off);
                        if (reg_wdata[17])
                            board_cmd.relay_on <= reg_wdata[16];
                        if (reg_wdata[19])
                            board_cmd.pwr_enable <= reg_wdata[18];
                        if (reg_wdata[23])
                            board_cmd.eth1394 <= reg_wdata[22];
                    end
                    REG_TIMEOUT: wdog_period <= reg_wdata[$bits(wdog_count_t)-1:0];
                    REG_DEBUG:   reg_debug   <= reg_wdata;
                    default: ;              // read-only or unmapped, ignore
                endcase
            end

            if (!reg_wen) begin
                if (read_main) begin
                    case (reg_raddr[3:0])
                        REG_STATUS:  reg_rdata <= reg_status;
                        REG_TIMEOUT: reg_rdata <= {16'd0, wdog_period};
                        REG_VERSION: reg_rdata <= BOARD_VERSION;
                        REG_TEMPSNS: reg_rdata <= {16'd0, board_io.temp_sense};
                        REG_DIGIN:   reg_rdata <= reg_digin;
                        REG_DEBUG:   reg_rdata <= reg_debug;
                        default:     reg_rdata <= '0;   // unmapped offset
                    endcase
                end else begin
                    reg_rdata <= '0;        // other blocks not in this design
                end

                // sticky disables, host must re-enable the axis
                amp_off <= amp_off | (wdog_timeout ? '1 : safety_amp_disable);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/power_seq.sv */
/*
 * Power sequencer: holds all amplifiers off until motor voltage has been
 * good for the settle time, then merges in the host amp-off state.
 */

`timescale 1ns/10ps
`default_nettype none

module power_seq (
    input  wire logic                  sysclk,
    input  wire logic                  rst_n,
    input  wire logic                  tick,        // timebase from watchdog
    input  wire logic                  mv_good,     // motor voltage good
    input  wire board_pkg::axis_mask_t amp_off,     // host/safety disables
    output board_pkg::axis_mask_t      amp_disable  // to the amplifier pins
);

    import board_pkg::*;

    pseq_state_t             state, state_nxt;
    logic [SETTLE_CNT_W-1:0] settle_cnt;    // ticks spent in PS_SETTLE

    // next state, mv_good loss always wins
    always_comb begin
        state_nxt = state;
        if (!mv_good) begin
            state_nxt = PS_OFF;
        end else begin
            case (state)
                PS_OFF:    state_nxt = PS_SETTLE;
                PS_SETTLE: if (tick && (settle_cnt == SETTLE_CNT_W'(MV_SETTLE_TICKS - 1)))
                               state_nxt = PS_READY;
                default:   state_nxt = state;   // PS_READY holds
            endcase
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= PS_OFF;
            settle_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state != PS_SETTLE)
                settle_cnt <= '0;               // restart on every entry
            else if (tick)
                settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // all-axes hold until voltage has settled
    assign amp_disable = amp_off | ((state == PS_READY) ? '0 : '1);

endmodule

`default_nettype wire

/* verilog/wdog_timer.sv */
/*
 * Host watchdog: a prescaler makes the sysclk tick enable, and a tick
 * counter flags a timeout when the host stops writing for a period.
 */

`timescale 1ns/10ps
`default_nettype none

module wdog_timer (
    input  wire logic                   sysclk,
    input  wire logic                   rst_n,
    input  wire board_pkg::wdog_count_t wdog_period,   // in ticks, 0 disables
    input  wire logic                   host_write,    // any register write
    input  wire logic                   powerup_cmd,   // clears count and flag
    output logic                        wdog_timeout,  // sticky
    output logic                        tick           // one sysclk every 2**TICK_WIDTH
);

    import board_pkg::*;

    logic [TICK_WIDTH-1:0] presc;       // free-running divider
    wdog_count_t           wdog_count;  // ticks since last host write

    // ----------------------------------------------------------
    // tick prescaler
    // ----------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
            tick  <= 1'b0;
        end else begin
            presc <= presc + 1'b1;
            tick  <= &presc;            // pulse on divider wrap
        end
    end

    // ----------------------------------------------------------
    // activity counter and timeout flag
    // ----------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (powerup_cmd) begin
            // host is bringing the board back up
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (host_write) begin
            wdog_count <= '0;           // host still alive
        end else if (tick && (wdog_period != '0)) begin
            if (wdog_count < wdog_period)
                wdog_count <= wdog_count + 1'b1;
            else
                wdog_timeout <= 1'b1;   // held until powerup_cmd
        end
    end

endmodule

`default_nettype wire
